/* logic/bpu_pkg.sv */
package bpu_pkg;

    // widths and table sizes
    localparam int xlen          = 32;
    localparam int hist_w        = 16;
    localparam int bm_entries    = 512;   // indexed by pc[9:1]
    localparam int tag_entries   = 256;   // per tagged table
    localparam int tag_w         = 10;
    localparam int partial_tag_w = 6;     // upper tag bits compared on lookup
    localparam int btb_entries   = 256;   // indexed by pc[9:2]
    localparam int btb_tag_w     = 22;    // pc[31:10]

    localparam logic [1:0] ctr_weak_nt = 2'b01;

    // which table supplied the direction
    typedef enum logic [1:0] {
        prov_bimodal = 2'd0,
        prov_t0      = 2'd1,
        prov_t1      = 2'd2
    } provider_e;

    // control transfer major opcodes
    typedef enum logic [6:0] {
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111
    } opcode_e;

    // fetch stage request
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } fetch_req_t;

    // direction predictor result
    typedef struct packed {
        logic              taken;
        provider_e         provider;
        logic [hist_w-1:0] history;   // ghr at lookup time
    } dir_pred_t;

    // target buffer result
    typedef struct packed {
        logic            hit;
        logic [xlen-1:0] target;
    } tgt_pred_t;

    // resolution coming back from execute
    typedef struct packed {
        logic              valid;
        logic              taken;
        logic              correct;   // prediction matched the outcome
        logic [xlen-1:0]   pc;
        logic [xlen-1:0]   target;
        logic [hist_w-1:0] history;   // snapshot returned with the prediction
        provider_e         provider;
    } ex_update_t;

    // final prediction to fetch
    typedef struct packed {
        logic              is_ctrl;
        logic              taken;
        logic [xlen-1:0]   next_pc;
        provider_e         provider;
        logic [hist_w-1:0] history;
    } bpu_pred_t;

endpackage

/* logic/tage_dir.sv */
`timescale 1ns/10ps

module tage_dir (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [bpu_pkg::xlen-1:0]     pc_i,
    input  bpu_pkg::ex_update_t          upd_i,
    output bpu_pkg::dir_pred_t           dir_o
);

    // global history, newest outcome in bit 0
    logic [bpu_pkg::hist_w-1:0] ghr;

    // bimodal base table
    logic [1:0] bm_ctr [bpu_pkg::bm_entries];

    // tagged tables, entry 0 is T0 and entry 1 is T1
    logic [bpu_pkg::tag_w-1:0] tg_tag [2][bpu_pkg::tag_entries];
    logic [1:0]                tg_ctr [2][bpu_pkg::tag_entries];

    // lookup side
    logic [8:0]                f_bm_idx;
    logic [7:0]                f_idx [2];
    logic [bpu_pkg::tag_w-1:0] f_tag [2];
    logic [1:0]                f_hit;

    // update side
    logic [8:0]                u_bm_idx;
    logic [7:0]                u_idx [2];
    logic [bpu_pkg::tag_w-1:0] u_tag [2];
    logic [1:0]                u_is_prov;
    logic [1:0]                u_alloc;
    logic                      bm_miss;

    // T0 folds in the low history byte, T1 the high one
    function automatic logic [7:0] tbl_idx(
        input int                         k,
        input logic [bpu_pkg::xlen-1:0]   pc,
        input logic [bpu_pkg::hist_w-1:0] h
    );
        logic [7:0] hb;
        hb = (k == 0) ? h[7:0] : h[15:8];
        return pc[7:0] ^ hb;
    endfunction

    function automatic logic [bpu_pkg::tag_w-1:0] tbl_tag(
        input int                         k,
        input logic [bpu_pkg::xlen-1:0]   pc,
        input logic [bpu_pkg::hist_w-1:0] h
    );
        logic [bpu_pkg::tag_w-1:0] mix;
        mix = (k == 0) ? h[15:6] : {2'b00, h[7:0]};
        return pc[17:8] ^ mix;
    endfunction

    // 2-bit saturating step toward the outcome
    function automatic logic [1:0] sat_ctr(input logic [1:0] ctr, input logic up);
        logic [1:0] nxt;
        nxt = ctr;
        if (up && ctr != 2'b11) begin
            nxt = ctr + 2'd1;
        end else if (!up && ctr != 2'b00) begin
            nxt = ctr - 2'd1;
        end
        return nxt;
    endfunction

    assign f_bm_idx = pc_i[9:1];
    assign u_bm_idx = upd_i.pc[9:1];

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            f_idx[k] = tbl_idx(k, pc_i, ghr);
            f_tag[k] = tbl_tag(k, pc_i, ghr);
            // partial match on the upper tag bits only
            f_hit[k] = tg_tag[k][f_idx[k]][bpu_pkg::tag_w-1 -: bpu_pkg::partial_tag_w] ==
                       f_tag[k][bpu_pkg::tag_w-1 -: bpu_pkg::partial_tag_w];
            u_idx[k] = tbl_idx(k, upd_i.pc, upd_i.history);
            u_tag[k] = tbl_tag(k, upd_i.pc, upd_i.history);
        end
    end

    // provider priority T1 > T0 > bimodal
    always_comb begin
        dir_o.history = ghr;
        if (f_hit[1]) begin
            dir_o.provider = bpu_pkg::prov_t1;
            dir_o.taken    = tg_ctr[1][f_idx[1]][1];
        end else if (f_hit[0]) begin
            dir_o.provider = bpu_pkg::prov_t0;
            dir_o.taken    = tg_ctr[0][f_idx[0]][1];
        end else begin
            dir_o.provider = bpu_pkg::prov_bimodal;
            dir_o.taken    = bm_ctr[f_bm_idx][1];
        end
    end

    assign u_is_prov[0] = upd_i.provider == bpu_pkg::prov_t0;
    assign u_is_prov[1] = upd_i.provider == bpu_pkg::prov_t1;

    // a wrong bimodal guess claims an entry, T1 first
    assign bm_miss    = upd_i.provider == bpu_pkg::prov_bimodal && !upd_i.correct;
    assign u_alloc[1] = bm_miss && (tg_tag[1][u_idx[1]] != u_tag[1]);
    assign u_alloc[0] = bm_miss && !u_alloc[1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghr <= '0;
        end else if (upd_i.valid) begin
            ghr <= {ghr[bpu_pkg::hist_w-2:0], upd_i.taken};
        end
    end

    // base table trains on every resolution
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bpu_pkg::bm_entries; i++) begin
                bm_ctr[i] <= bpu_pkg::ctr_weak_nt;
            end
        end else if (upd_i.valid) begin
            bm_ctr[u_bm_idx] <= sat_ctr(bm_ctr[u_bm_idx], upd_i.taken);
        end
    end

    for (genvar k = 0; k < 2; k++) begin : g_tagged
        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                for (int i = 0; i < bpu_pkg::tag_entries; i++) begin
                    tg_tag[k][i] <= '0;
                    tg_ctr[k][i] <= bpu_pkg::ctr_weak_nt;
                end
            end else if (upd_i.valid) begin
                if (u_is_prov[k]) begin
                    if (upd_i.correct) begin
                        tg_ctr[k][u_idx[k]] <= sat_ctr(tg_ctr[k][u_idx[k]], upd_i.taken);
                    end else begin
                        tg_ctr[k][u_idx[k]] <= {2{upd_i.taken}};  // strongly the outcome
                    end
                end else if (u_alloc[k]) begin
                    tg_tag[k][u_idx[k]] <= u_tag[k];
                    tg_ctr[k][u_idx[k]] <= {upd_i.taken, ~upd_i.taken};  // weak toward outcome
                end
            end
        end
    end

    // provider comes back from fetch through execute, must be a real table
    a_prov_legal: assert property (
        @(posedge clk) disable iff (rst)
        upd_i.valid |-> upd_i.provider inside
            {bpu_pkg::prov_bimodal, bpu_pkg::prov_t0, bpu_pkg::prov_t1}
    );

endmodule

/* logic/btb.sv */
`timescale 1ns/10ps

module btb (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::xlen-1:0] pc_i,
    input  bpu_pkg::ex_update_t      upd_i,
    output bpu_pkg::tgt_pred_t       tgt_o
);

    // direct mapped, one entry per pc[9:2]
    logic [bpu_pkg::btb_tag_w-1:0] bt_tag [bpu_pkg::btb_entries];
    logic [bpu_pkg::xlen-1:0]      bt_tgt [bpu_pkg::btb_entries];
    logic [bpu_pkg::btb_entries-1:0] bt_vld;

    logic [7:0]                    f_idx;
    logic [bpu_pkg::btb_tag_w-1:0] f_tag;
    logic [7:0]                    u_idx;
    logic [bpu_pkg::btb_tag_w-1:0] u_tag;
    logic                          wr_en;

    assign f_idx = pc_i[9:2];
    assign f_tag = pc_i[bpu_pkg::xlen-1 -: bpu_pkg::btb_tag_w];   // pc[31:10]

    assign u_idx = upd_i.pc[9:2];
    assign u_tag = upd_i.pc[bpu_pkg::xlen-1 -: bpu_pkg::btb_tag_w];

    // only taken resolutions are worth caching
    assign wr_en = upd_i.valid && upd_i.taken;

    // hit needs valid and the full tag
    always_comb begin
        tgt_o.hit    = bt_vld[f_idx] && (bt_tag[f_idx] == f_tag);
        tgt_o.target = bt_tgt[f_idx];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bt_vld <= '0;
        end else if (wr_en) begin
            bt_vld[u_idx] <= 1'b1;
        end
    end

    // tag and target storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            bt_tag[u_idx] <= u_tag;
            bt_tgt[u_idx] <= upd_i.target;
        end
    end

    // execute hands back RV32C-compatible targets only
    a_tgt_align: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> upd_i.target[0] == 1'b0
    );

endmodule

/* logic/pred_select.sv */
`timescale 1ns/10ps

module pred_select (
    input  bpu_pkg::fetch_req_t fetch_i,
    input  bpu_pkg::dir_pred_t  dir_i,
    input  bpu_pkg::tgt_pred_t  tgt_i,
    output bpu_pkg::bpu_pred_t  pred_o
);

    logic [6:0]               opcode;
    logic [bpu_pkg::xlen-1:0] imm_j;     // jal offset
    logic [bpu_pkg::xlen-1:0] imm_b;     // conditional branch offset
    logic [bpu_pkg::xlen-1:0] pc_plus4;
    logic [bpu_pkg::xlen-1:0] jal_tgt;
    logic [bpu_pkg::xlen-1:0] br_tgt;

    assign opcode = fetch_i.inst[6:0];

    // J-type immediate, sign extended
    assign imm_j = {
        {12{fetch_i.inst[31]}},
        fetch_i.inst[19:12],
        fetch_i.inst[20],
        fetch_i.inst[30:21],
        1'b0
    };

    // B-type immediate, sign extended
    assign imm_b = {
        {20{fetch_i.inst[31]}},
        fetch_i.inst[7],
        fetch_i.inst[30:25],
        fetch_i.inst[11:8],
        1'b0
    };

    assign pc_plus4 = fetch_i.pc + 32'd4;

    // btb wins over the decoded offset when it hits
    assign jal_tgt = tgt_i.hit ? tgt_i.target : fetch_i.pc + imm_j;
    assign br_tgt  = tgt_i.hit ? tgt_i.target : fetch_i.pc + imm_b;

    always_comb begin
        pred_o.is_ctrl  = 1'b0;
        pred_o.taken    = 1'b0;
        pred_o.next_pc  = pc_plus4;
        pred_o.provider = dir_i.provider;   // returned later with the feedback
        pred_o.history  = dir_i.history;

        case (opcode)
            bpu_pkg::op_jal: begin
                pred_o.is_ctrl = 1'b1;
                pred_o.taken   = 1'b1;    // always taken
                pred_o.next_pc = jal_tgt;
            end
            bpu_pkg::op_jalr: begin
                // register target, only the btb can know it
                pred_o.is_ctrl = 1'b1;
                if (tgt_i.hit) begin
                    pred_o.taken   = 1'b1;
                    pred_o.next_pc = tgt_i.target;
                end
            end
            bpu_pkg::op_branch: begin
                pred_o.is_ctrl = 1'b1;
                pred_o.taken   = dir_i.taken;
                if (dir_i.taken) begin
                    pred_o.next_pc = br_tgt;
                end
            end
            default: begin
                // not a control transfer, fall through
            end
        endcase
    end

endmodule

/* logic/bpu_top.sv */
`timescale 1ns/10ps

module bpu_top (
    input  logic                clk,
    input  logic                rst,
    input  bpu_pkg::fetch_req_t fetch_i,
    input  bpu_pkg::ex_update_t ex_i,
    output bpu_pkg::bpu_pred_t  pred_o
);

    bpu_pkg::dir_pred_t dir;   // direction from the tagged predictor
    bpu_pkg::tgt_pred_t tgt;   // target from the btb

    tage_dir u_tage_dir (
        .clk   (clk),
        .rst   (rst),
        .pc_i  (fetch_i.pc),
        .upd_i (ex_i),
        .dir_o (dir)
    );

    btb u_btb (
        .clk   (clk),
        .rst   (rst),
        .pc_i  (fetch_i.pc),
        .upd_i (ex_i),
        .tgt_o (tgt)
    );

    // decode and merge into the fetch redirect
    pred_select u_pred_select (
        .fetch_i (fetch_i),
        .dir_i   (dir),
        .tgt_i   (tgt),
        .pred_o  (pred_o)
    );

endmodule

/* tb/tb_bpu.sv */
`timescale 1ns/10ps

module tb_bpu;

    localparam int n_jump  = 4;
    localparam int n_btb   = 2;
    localparam int n_hist  = 20;
    localparam int n_warm  = 16;   // fills the whole history
    localparam int n_train = 3;

    // cycles per test summed for the watchdog
    localparam int len_all = 4 + 3 + 2 * n_jump + 6 * n_btb + 2 * n_hist
                             + 2 * (2 * (n_warm + n_train) + 1);
    localparam int max_cycles = 2 * len_all;

    logic                clk;
    logic                rst;
    bpu_pkg::fetch_req_t fetch;
    bpu_pkg::ex_update_t ex;
    bpu_pkg::bpu_pred_t  pred;

    // phase enables and expected values for the checkers
    logic                       chk_pred;
    logic                       chk_hist;
    logic                       chk_alias;
    logic                       chk_prov;
    logic                       exp_ctrl;
    logic                       exp_taken;
    logic [bpu_pkg::xlen-1:0]   exp_npc;
    logic [bpu_pkg::hist_w-1:0] exp_hist;
    logic [bpu_pkg::xlen-1:0]   alias_tgt;
    bpu_pkg::provider_e         exp_prov;

    int err_cnt;
    int n_checks;
    int tests_ok;
    int tests_bad;
    int test_err0;
    int cycles;

    bpu_top u_bpu_top (
        .clk     (clk),
        .rst     (rst),
        .fetch_i (fetch),
        .ex_i    (ex),
        .pred_o  (pred)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: no result after %0d cycles", max_cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    a_is_ctrl: assert property (@(posedge clk) disable iff (rst)
        chk_pred |-> pred.is_ctrl == exp_ctrl)
    else begin
        $display("** Error: pred_o.is_ctrl = %h, expected %h",
                 $sampled(pred.is_ctrl), $sampled(exp_ctrl));
        err_cnt++;
    end

    a_taken: assert property (@(posedge clk) disable iff (rst)
        chk_pred |-> pred.taken == exp_taken)
    else begin
        $display("** Error: pred_o.taken = %h, expected %h",
                 $sampled(pred.taken), $sampled(exp_taken));
        err_cnt++;
    end

    a_next_pc: assert property (@(posedge clk) disable iff (rst)
        chk_pred |-> pred.next_pc == exp_npc)
    else begin
        $display("** Error: pred_o.next_pc = %h, expected %h",
                 $sampled(pred.next_pc), $sampled(exp_npc));
        err_cnt++;
    end

    a_history: assert property (@(posedge clk) disable iff (rst)
        chk_hist |-> pred.history == exp_hist)
    else begin
        $display("** Error: pred_o.history = %h, expected %h",
                 $sampled(pred.history), $sampled(exp_hist));
        err_cnt++;
    end

    a_provider: assert property (@(posedge clk) disable iff (rst)
        chk_prov |-> pred.provider == exp_prov)
    else begin
        $display("** Error: pred_o.provider = %h, expected %h",
                 $sampled(pred.provider), $sampled(exp_prov));
        err_cnt++;
    end

    // same btb index but another tag
    a_alias: assert property (@(posedge clk) disable iff (rst)
        chk_alias |-> pred.next_pc != alias_tgt)
    else begin
        $display("** Error: pred_o.next_pc = %h, must not be aliased target %h",
                 $sampled(pred.next_pc), $sampled(alias_tgt));
        err_cnt++;
    end

    // RV32I encodings
    function automatic logic [31:0] jal_inst(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, bpu_pkg::op_jal};
    endfunction

    function automatic logic [31:0] jalr_inst();
        return {12'h000, 5'd1, 3'b000, 5'd0, bpu_pkg::op_jalr};   // ret
    endfunction

    function automatic logic [31:0] branch_inst(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11],
                bpu_pkg::op_branch};
    endfunction

    function automatic logic [31:0] alu_inst();
        return {12'h001, 5'd0, 3'b000, 5'd3, 7'b0010011};   // addi x3, x0, 1
    endfunction

    function automatic logic [31:0] sext_j(input logic [20:0] imm);
        return {{11{imm[20]}}, imm};
    endfunction

    function automatic logic [31:0] sext_b(input logic [12:0] imm);
        return {{19{imm[12]}}, imm};
    endfunction

    // word aligned below 1024 so pc+1024 changes only the btb tag
    function automatic logic [31:0] rand_pc();
        return $urandom() & 32'h0000_03fc;
    endfunction

    function automatic logic [20:0] rand_jimm();
        logic [20:0] r;
        r = 21'($urandom());
        r[0] = 1'b0;
        return r;
    endfunction

    function automatic logic [12:0] rand_bimm();
        logic [12:0] r;
        r = 13'($urandom());
        r[0] = 1'b0;
        return r;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    // one fetch checked at the following edge
    task automatic check_pred(input logic [31:0] pc, input logic [31:0] inst,
                              input logic ctrl, input logic tk, input logic [31:0] npc);
        fetch.pc   = pc;
        fetch.inst = inst;
        exp_ctrl   = ctrl;
        exp_taken  = tk;
        exp_npc    = npc;
        chk_pred   = 1'b1;
        n_checks++;
        next_cycle();
        chk_pred = 1'b0;
    endtask

    // fetch then resolve with the returned history and provider
    task automatic resolve_branch(input logic [31:0] pc, input logic [31:0] inst,
                                  input logic tk, input logic [31:0] tgt);
        bpu_pkg::bpu_pred_t snap;
        fetch.pc   = pc;
        fetch.inst = inst;
        ex.valid   = 1'b0;
        ex.taken   = 1'b1;   // must be ignored while valid is low
        #40;
        snap = pred;         // mid-cycle
        next_cycle();
        ex.valid    = 1'b1;
        ex.taken    = tk;
        ex.correct  = snap.taken == tk;
        ex.pc       = pc;
        ex.target   = tgt;
        ex.history  = snap.history;
        ex.provider = snap.provider;
        next_cycle();
        ex.valid = 1'b0;
        exp_hist = {exp_hist[bpu_pkg::hist_w-2:0], tk};
    endtask

    task automatic close_test(input string name);
        if (err_cnt == test_err0) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: %0d errors", name, err_cnt - test_err0);
            tests_bad++;
        end
        test_err0 = err_cnt;
    endtask

    initial begin
        logic [bpu_pkg::xlen-1:0] pc;
        logic [bpu_pkg::xlen-1:0] tgt;
        logic [20:0]              jimm;
        logic [12:0]              bimm;
        logic                     tk;

        void'($urandom(32'hfa98));
        clk       = 1'b0;
        rst       = 1'b1;
        fetch     = '0;
        ex        = '0;
        chk_pred  = 1'b0;
        chk_hist  = 1'b0;
        chk_alias = 1'b0;
        chk_prov  = 1'b0;
        exp_ctrl  = 1'b0;
        exp_taken = 1'b0;
        exp_npc   = '0;
        exp_hist  = '0;
        alias_tgt = '0;
        exp_prov  = bpu_pkg::prov_bimodal;
        err_cnt   = 0;
        n_checks  = 0;
        tests_ok  = 0;
        tests_bad = 0;
        test_err0 = 0;
        cycles    = 0;

        repeat (3) @(posedge clk);
        #10;
        rst      = 1'b0;
        chk_hist = 1'b1;   // history tracked from here on

        // cold tables with every counter weakly not taken
        // zero history against zero tags hits in T1 first
        exp_prov = bpu_pkg::prov_t1;
        chk_prov = 1'b1;
        pc = rand_pc();
        check_pred(pc, alu_inst(), 1'b0, 1'b0, pc + 4);
        pc   = rand_pc();
        bimm = rand_bimm();
        check_pred(pc, branch_inst(bimm), 1'b1, 1'b0, pc + 4);
        chk_prov = 1'b0;
        close_test("cold");

        for (int i = 0; i < n_jump; i++) begin
            pc   = rand_pc();
            jimm = rand_jimm();
            check_pred(pc, jal_inst(jimm), 1'b1, 1'b1, pc + sext_j(jimm));
            check_pred(pc, jalr_inst(), 1'b1, 1'b0, pc + 4);
        end
        close_test("jump");

        for (int i = 0; i < n_btb; i++) begin
            pc   = rand_pc();
            jimm = rand_jimm();
            tgt  = 32'h8000_0000 | ($urandom() & 32'h0000_fffe);  // out of jal reach
            resolve_branch(pc, jal_inst(jimm), 1'b1, tgt);
            check_pred(pc, jal_inst(jimm), 1'b1, 1'b1, tgt);
            check_pred(pc, jalr_inst(), 1'b1, 1'b1, tgt);
            alias_tgt = tgt;
            chk_alias = 1'b1;
            check_pred(pc + 1024, jal_inst(jimm), 1'b1, 1'b1, pc + 1024 + sext_j(jimm));
            check_pred(pc + 1024, jalr_inst(), 1'b1, 1'b0, pc + 1028);
            chk_alias = 1'b0;
        end
        close_test("btb");

        // random outcomes with idle cycles between them
        for (int i = 0; i < n_hist; i++) begin
            pc   = rand_pc();
            bimm = rand_bimm();
            tk   = 1'($urandom());
            resolve_branch(pc, branch_inst(bimm), tk, pc + sext_b(bimm));
        end
        close_test("history");

        pc   = rand_pc();
        bimm = rand_bimm();
        for (int i = 0; i < n_warm + n_train; i++) begin
            resolve_branch(pc, branch_inst(bimm), 1'b1, pc + sext_b(bimm));
        end
        check_pred(pc, branch_inst(bimm), 1'b1, 1'b1, pc + sext_b(bimm));
        for (int i = 0; i < n_warm + n_train; i++) begin
            resolve_branch(pc, branch_inst(bimm), 1'b0, pc + 4);
        end
        check_pred(pc, branch_inst(bimm), 1'b1, 1'b0, pc + 4);
        close_test("direction");

        $display("%0d tests passed, %0d failed, %0d errors in %0d prediction checks",
                 tests_ok, tests_bad, err_cnt, n_checks);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* flist.f */
logic/bpu_pkg.sv
logic/tage_dir.sv
logic/btb.sv
logic/pred_select.sv
logic/bpu_top.sv
tb/tb_bpu.sv
